/* verification/wired_tl_adapter_asserts.sv */
// handshake rules of the uncached path, checked only while rst_n is high
`timescale 1ns/1ps

module wired_tl_adapter_asserts import wired_tl_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               tl_a_valid_o,
    input logic               tl_a_ready_i,
    input tl_a_op_e           tl_a_opcode_o,
    input tl_size_t           tl_a_size_o,
    input logic [PADDR_W-1:0] tl_a_address_o,
    input line_strb_t         tl_a_mask_o,
    input line_data_t         tl_a_data_o,
    input logic               resp_ready_o,
    input logic               tl_d_valid_i,
    input logic               tl_d_ready_o
);

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    // stalled a beat keeps valid and payload
    a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tl_a_valid_o && !tl_a_ready_i |=> tl_a_valid_o &&
        $stable({tl_a_opcode_o, tl_a_size_o, tl_a_address_o, tl_a_mask_o, tl_a_data_o}))
        else begin
            fail_cnt++;
            $error("channel A beat changed while stalled");
        end

    resp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp_ready_o |=> !resp_ready_o)
        else begin
            fail_cnt++;
            $error("resp_ready_o held longer than one cycle");
        end

    d_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        tl_d_ready_o |-> tl_d_valid_i)
        else begin
            fail_cnt++;
            $error("tl_d_ready_o high without tl_d_valid_i");
        end

endmodule

bind wired_tl_adapter wired_tl_adapter_asserts asserts_i (.*);

/* verification/wired_tl_adapter_tb.sv */
// inputs change on the falling edge, the slave model serves one request at a time
`timescale 1ns/1ps

module wired_tl_adapter_tb import wired_tl_pkg::*; ();

    localparam int PERIOD      = 8;
    localparam int RST_CYCLES  = 8;
    localparam int MAX_STALL   = 3;   // 2 lfsr bits per stall
    localparam int RESP_CYCLES = 10;
    localparam int NUM_TESTS   = 12;
    localparam int WATCHDOG_NS =
        (RST_CYCLES + NUM_TESTS * (2 * MAX_STALL + RESP_CYCLES)) * PERIOD;
    localparam logic [31:0] SEED = 32'h086d6a71;
    localparam logic [1:0] K_LD = 2'd0;
    localparam logic [1:0] K_ST = 2'd1;
    localparam logic [1:0] K_WB = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  way;
        logic [3:0]  strb;
        logic [15:0] mask;   // expected a mask
        logic [2:0]  op;     // expected a opcode
    } vec_t;

    localparam vec_t VECS [NUM_TESTS] = '{
        '{K_LD, 2'd0, 32'h8000_0005, 32'h0000_0000, 2'd0, 4'h0, 16'h0020, 3'd4},
        '{K_LD, 2'd1, 32'h8000_100a, 32'h0000_0000, 2'd0, 4'h0, 16'h0c00, 3'd4},
        '{K_LD, 2'd2, 32'h8000_2004, 32'h0000_0000, 2'd0, 4'h0, 16'h00f0, 3'd4},
        '{K_LD, 2'd3, 32'h8000_3008, 32'h0000_0000, 2'd0, 4'h0, 16'hff00, 3'd4},
        '{K_LD, 2'd3, 32'h8000_3000, 32'h0000_0000, 2'd0, 4'h0, 16'h00ff, 3'd4},
        '{K_ST, 2'd0, 32'h9000_0003, 32'h0000_00a5, 2'd0, 4'h0, 16'h0008, 3'd0},
        '{K_ST, 2'd1, 32'h9000_000c, 32'h0000_beef, 2'd0, 4'h0, 16'h3000, 3'd0},
        '{K_ST, 2'd2, 32'h9000_0008, 32'hdead_beef, 2'd0, 4'h0, 16'h0f00, 3'd0},
        '{K_WB, 2'd0, 32'h0000_05a4, 32'h1234_5678, 2'd2, 4'h6, 16'h0000, 3'd0},
        '{K_WB, 2'd0, 32'h0000_0ffc, 32'hcafe_f00d, 2'd3, 4'hf, 16'h0000, 3'd0},
        '{K_ST, 2'd0, 32'h9000_0006, 32'h0000_005a, 2'd0, 4'h0, 16'h0040, 3'd0},
        '{K_LD, 2'd1, 32'h8000_0002, 32'h0000_0000, 2'd0, 4'h0, 16'h000c, 3'd4}
    };

    logic clk, rst_n;
    logic req_valid_i, req_uncached_load_i, req_uncached_store_i;
    logic [1:0] req_size_i;
    logic [PADDR_W-1:0] req_paddr_i;
    logic [WORD_W-1:0] req_wdata_i, wb_wdata_i;
    logic resp_ready_o;
    logic [63:0] resp_rdata_o;
    logic wb_req_i;
    logic [WAY_W-1:0] wb_way_i, m_way_o;
    logic [SRAM_ADDR_W-1:0] wb_addr_i, m_addr_o;
    word_strb_t wb_wstrb_i;
    line_strb_t m_wstrb_o, tl_a_mask_o;
    line_data_t m_wdata_o, tl_a_data_o, tl_d_data_i;
    logic tl_a_valid_o, tl_a_ready_i, tl_d_valid_i, tl_d_ready_o;
    tl_a_op_e tl_a_opcode_o;
    tl_size_t tl_a_size_o;
    logic [PADDR_W-1:0] tl_a_address_o;
    tl_d_op_e tl_d_opcode_i;
    logic [31:0] lfsr_state = SEED;
    int err_cnt = 0;
    int chk_cnt = 0;

    wired_tl_adapter dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = step_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic run_access(input vec_t v);
        line_data_t exp_data;
        line_data_t d_line;
        int cyc;
        int stall;
        exp_data = '0;
        if (v.kind == K_ST) exp_data[v.addr[3:2]] = v.wdata;
        req_valid_i          = 1'b1;
        req_uncached_load_i  = (v.kind == K_LD);
        req_uncached_store_i = (v.kind == K_ST);
        req_size_i           = v.size;
        req_paddr_i          = v.addr;
        req_wdata_i          = v.wdata;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!tl_a_valid_o && cyc < 8);
        check_val("tl_a_valid_o delay", cyc, 2);
        check_val("tl_a_opcode_o", tl_a_opcode_o, v.op);
        check_val("tl_a_address_o", tl_a_address_o, v.addr);
        check_val("tl_a_size_o", tl_a_size_o, v.size);
        check_val("tl_a_mask_o", tl_a_mask_o, v.mask);
        check_val("tl_a_data_o", tl_a_data_o, exp_data);
        stall = take_bits(2);
        repeat (stall) begin
            @(negedge clk);
            check_val("tl_a_valid_o", tl_a_valid_o, 1);
        end
        tl_a_ready_i = 1'b1;
        @(negedge clk);
        tl_a_ready_i = 1'b0;
        stall = take_bits(2);
        repeat (stall) @(negedge clk);
        // wrong opcode first, must be refused
        tl_d_valid_i  = 1'b1;
        tl_d_opcode_i = (v.kind == K_ST) ? D_ACCESS_ACK_DATA : D_ACCESS_ACK;
        #1 check_val("tl_d_ready_o", tl_d_ready_o, 0);
        @(negedge clk);
        for (int w = 0; w < LINE_WORDS; w++) d_line[w] = take_bits(32);
        tl_d_opcode_i = (v.kind == K_ST) ? D_ACCESS_ACK : D_ACCESS_ACK_DATA;
        tl_d_data_i   = d_line;
        #1 check_val("tl_d_ready_o", tl_d_ready_o, 1);
        check_val("resp_ready_o", resp_ready_o, v.kind == K_ST);  // stores answer at once
        @(negedge clk);
        tl_d_valid_i = 1'b0;
        check_val("resp_ready_o", resp_ready_o, v.kind == K_LD);
        if (v.kind == K_LD) begin
            check_val("resp_rdata_o", resp_rdata_o,
                      {d_line[{v.addr[3], 1'b1}], d_line[v.addr[3:2]]});
        end
        req_valid_i          = 1'b0;
        req_uncached_load_i  = 1'b0;
        req_uncached_store_i = 1'b0;
        @(negedge clk);  // request fsm back in free
    endtask

    task automatic run_writeback(input vec_t v);
        line_strb_t exp_strb;
        line_data_t exp_data;
        exp_strb = '0;
        exp_data = '0;
        exp_strb[v.addr[3:2]] = v.strb;
        exp_data[v.addr[3:2]] = v.wdata;
        wb_req_i   = 1'b1;
        wb_way_i   = v.way;
        wb_addr_i  = v.addr[11:0];
        wb_wstrb_i = v.strb;
        wb_wdata_i = v.wdata;
        #1 check_val("m_way_o", m_way_o, v.way);
        check_val("m_addr_o", m_addr_o, {v.addr[11:4], 4'h0});
        check_val("m_wstrb_o", m_wstrb_o, exp_strb);
        check_val("m_wdata_o", m_wdata_o, exp_data);
        @(negedge clk);
        wb_req_i = 1'b0;
        #1 check_val("m_way_o", m_way_o, 0);
        check_val("m_addr_o", m_addr_o, 0);
        check_val("m_wstrb_o", m_wstrb_o, 0);
        check_val("m_wdata_o", m_wdata_o, 0);
        @(negedge clk);
    endtask

    initial begin
        int errs_before;
        int total_errs;
        rst_n = 1'b0;
        {req_valid_i, req_uncached_load_i, req_uncached_store_i} = '0;
        {req_size_i, req_paddr_i, req_wdata_i} = '0;
        {wb_req_i, wb_way_i, wb_addr_i, wb_wstrb_i, wb_wdata_i} = '0;
        {tl_a_ready_i, tl_d_valid_i, tl_d_data_i} = '0;
        tl_d_opcode_i = D_ACCESS_ACK;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        check_val("resp_ready_o", resp_ready_o, 0);
        check_val("tl_a_valid_o", tl_a_valid_o, 0);
        check_val("tl_d_ready_o", tl_d_ready_o, 0);
        check_val("m_wstrb_o", m_wstrb_o, 0);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            errs_before = err_cnt;
            if (VECS[i].kind == K_WB) run_writeback(VECS[i]);
            else run_access(VECS[i]);
            $display("test %0d %s %s", i,
                     (VECS[i].kind == K_LD) ? "load" :
                     (VECS[i].kind == K_ST) ? "store" : "writeback",
                     (err_cnt == errs_before) ? "ok" : "mismatch");
        end
        repeat (2) @(negedge clk);
        total_errs = err_cnt + dut_i.asserts_i.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, chk_cnt, err_cnt, dut_i.asserts_i.fail_cnt);
        if (total_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // hang guard sized from the table length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verilog/cpu_req_ctrl.sv */
// requests are ignored while busy and the cpu must hold them until resp_ready_o pulses
`timescale 1ns/1ps

module cpu_req_ctrl import wired_tl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid_i,
    input  logic                   req_uncached_load_i,
    input  logic                   req_uncached_store_i,
    input  logic [1:0]             req_size_i,
    input  logic [PADDR_W-1:0]     req_paddr_i,
    input  logic [WORD_W-1:0]      req_wdata_i,
    input  logic                   wb_req_i,
    input  logic [WAY_W-1:0]       wb_way_i,
    input  logic [SRAM_ADDR_W-1:0] wb_addr_i,
    input  word_strb_t             wb_wstrb_i,
    input  logic [WORD_W-1:0]      wb_wdata_i,
    input  logic                   unc_done_i,
    input  line_data_t             unc_rdata_i,
    output logic                   resp_ready_o,
    output logic [63:0]            resp_rdata_o,
    output logic                   unc_call_o,
    output logic                   unc_wreq_o,
    output logic [PADDR_W-1:0]     unc_addr_o,
    output tl_size_t               unc_size_o,
    output line_strb_t             unc_mask_o,
    output line_data_t             unc_wdata_o,
    output logic [WAY_W-1:0]       m_way_o,
    output logic [SRAM_ADDR_W-1:0] m_addr_o,
    output line_strb_t             m_wstrb_o,
    output line_data_t             m_wdata_o
);

    typedef enum logic [1:0] {
        S_FREE = 2'd0,
        S_ULD  = 2'd1,  // calling the master with a get
        S_UST  = 2'd2,  // calling the master with a put
        S_RET  = 2'd3   // load data registered, answer the cpu
    } crq_state_e;

    crq_state_e         state_q;
    crq_state_e         state_d;
    logic [1:0]         size_q;
    logic [PADDR_W-1:0] addr_q;
    logic [WORD_W-1:0]  wdata_q;
    logic [63:0]        rdata_q;
    word_strb_t         word_strb;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FREE: begin
                // store wins when both flags are up
                if (req_valid_i && req_uncached_store_i) begin
                    state_d = S_UST;
                end else if (req_valid_i && req_uncached_load_i) begin
                    state_d = S_ULD;
                end
            end
            S_ULD:   if (unc_done_i) state_d = S_RET;
            S_UST:   if (unc_done_i) state_d = S_FREE;
            default: state_d = S_FREE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_FREE;
        end else begin
            state_q <= state_d;
        end
    end

    // request payload, loaded on acceptance
    always_ff @(posedge clk) begin
        if (state_q == S_FREE && state_d != S_FREE) begin
            size_q  <= req_size_i;
            addr_q  <= req_paddr_i;
            wdata_q <= req_wdata_i;
        end
        if (state_q == S_ULD && unc_done_i) begin
            rdata_q <= {unc_rdata_i[{addr_q[3], 1'b1}], unc_rdata_i[addr_q[3:2]]};
        end
    end

    // byte strobe inside the addressed word
    always_comb begin
        case (size_q)
            SZ_BYTE: word_strb = 4'b0001 << addr_q[1:0];
            SZ_HALF: word_strb = addr_q[1] ? 4'b1100 : 4'b0011;
            default: word_strb = 4'b1111;
        endcase
    end

    always_comb begin
        unc_mask_o  = '0;
        unc_wdata_o = '0;
        unc_mask_o[addr_q[3:2]]  = word_strb;
        unc_wdata_o[addr_q[3:2]] = wdata_q;
        if (size_q == SZ_DWORD) begin
            unc_mask_o[{addr_q[3], 1'b1}] = 4'b1111;  // upper half of the doubleword
        end
    end

    assign unc_call_o   = (state_q == S_ULD) || (state_q == S_UST);
    assign unc_wreq_o   = (state_q == S_UST);
    assign unc_addr_o   = addr_q;
    assign unc_size_o   = {2'b00, size_q};
    assign resp_ready_o = (state_q == S_RET) || (state_q == S_UST && unc_done_i);
    assign resp_rdata_o = rdata_q;

    // writeback lands in its own lane of the sram line
    always_comb begin
        m_way_o   = '0;
        m_addr_o  = '0;
        m_wstrb_o = '0;
        m_wdata_o = '0;
        if (wb_req_i) begin
            m_way_o  = wb_way_i;
            m_addr_o = {wb_addr_i[SRAM_ADDR_W-1:4], 4'b0000};
            m_wstrb_o[wb_addr_i[3:2]] = wb_wstrb_i;
            m_wdata_o[wb_addr_i[3:2]] = wb_wdata_i;
        end
    end

endmodule

/* verilog/uncached_tl_master.sv */
// one outstanding request with fixed source and param, only single-beat d responses
`timescale 1ns/1ps

module uncached_tl_master import wired_tl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               unc_call_i,
    input  logic               unc_wreq_i,
    input  logic [PADDR_W-1:0] unc_addr_i,
    input  tl_size_t           unc_size_i,
    input  line_strb_t         unc_mask_i,
    input  line_data_t         unc_wdata_i,
    output logic               unc_done_o,
    output line_data_t         unc_rdata_o,
    output logic               tl_a_valid_o,
    input  logic               tl_a_ready_i,
    output tl_a_op_e           tl_a_opcode_o,
    output tl_size_t           tl_a_size_o,
    output logic [PADDR_W-1:0] tl_a_address_o,
    output line_strb_t         tl_a_mask_o,
    output line_data_t         tl_a_data_o,
    input  logic               tl_d_valid_i,
    output logic               tl_d_ready_o,
    input  tl_d_op_e           tl_d_opcode_i,
    input  line_data_t         tl_d_data_i
);

    typedef enum logic [1:0] {
        S_FREE = 2'd0,
        S_TLA  = 2'd1,  // a beat on the bus
        S_WTLD = 2'd2,  // waiting for AccessAck
        S_RTLD = 2'd3   // waiting for AccessAckData
    } unc_state_e;

    unc_state_e         state_q;
    unc_state_e         state_d;
    logic               wreq_q;
    logic [PADDR_W-1:0] addr_q;
    tl_size_t           size_q;
    line_strb_t         mask_q;
    line_data_t         data_q;
    logic               d_match;

    // only the opcode answering the pending request is taken
    always_comb begin
        d_match = 1'b0;
        if (state_q == S_WTLD) begin
            d_match = tl_d_valid_i && (tl_d_opcode_i == D_ACCESS_ACK);
        end else if (state_q == S_RTLD) begin
            d_match = tl_d_valid_i && (tl_d_opcode_i == D_ACCESS_ACK_DATA);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FREE: if (unc_call_i) state_d = S_TLA;
            S_TLA: begin
                if (tl_a_ready_i) begin
                    state_d = wreq_q ? S_WTLD : S_RTLD;
                end
            end
            default: if (d_match) state_d = S_FREE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_FREE;
        end else begin
            state_q <= state_d;
        end
    end

    // call payload held for the whole a beat
    always_ff @(posedge clk) begin
        if (state_q == S_FREE && unc_call_i) begin
            wreq_q <= unc_wreq_i;
            addr_q <= unc_addr_i;
            size_q <= unc_size_i;
            mask_q <= unc_mask_i;
            data_q <= unc_wreq_i ? unc_wdata_i : '0;  // get carries no data
        end
    end

    always_comb begin
        if (wreq_q) begin
            tl_a_opcode_o = A_PUT_FULL_DATA;
        end else begin
            tl_a_opcode_o = A_GET;
        end
    end

    assign tl_a_valid_o   = (state_q == S_TLA);
    assign tl_a_size_o    = size_q;
    assign tl_a_address_o = addr_q;
    assign tl_a_mask_o    = mask_q;
    assign tl_a_data_o    = data_q;

    assign tl_d_ready_o = d_match;
    assign unc_done_o   = d_match;
    assign unc_rdata_o  = tl_d_data_i;  // sampled by the caller on unc_done_o

endmodule

/* verilog/wired_tl_adapter.sv */
// uncached cpu path only, stores limited to sizes 0-2 and single-beat d responses
`timescale 1ns/1ps

module wired_tl_adapter import wired_tl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // cpu request side
    input  logic                   req_valid_i,
    input  logic                   req_uncached_load_i,
    input  logic                   req_uncached_store_i,
    input  logic [1:0]             req_size_i,
    input  logic [PADDR_W-1:0]     req_paddr_i,
    input  logic [WORD_W-1:0]      req_wdata_i,
    output logic                   resp_ready_o,
    output logic [63:0]            resp_rdata_o,
    // line writeback from the cpu
    input  logic                   wb_req_i,
    input  logic [WAY_W-1:0]       wb_way_i,
    input  logic [SRAM_ADDR_W-1:0] wb_addr_i,
    input  word_strb_t             wb_wstrb_i,
    input  logic [WORD_W-1:0]      wb_wdata_i,
    // data sram port
    output logic [WAY_W-1:0]       m_way_o,
    output logic [SRAM_ADDR_W-1:0] m_addr_o,
    output line_strb_t             m_wstrb_o,
    output line_data_t             m_wdata_o,
    // tilelink channel a
    output logic                   tl_a_valid_o,
    input  logic                   tl_a_ready_i,
    output tl_a_op_e               tl_a_opcode_o,
    output tl_size_t               tl_a_size_o,
    output logic [PADDR_W-1:0]     tl_a_address_o,
    output line_strb_t             tl_a_mask_o,
    output line_data_t             tl_a_data_o,
    // tilelink channel d
    input  logic                   tl_d_valid_i,
    output logic                   tl_d_ready_o,
    input  tl_d_op_e               tl_d_opcode_i,
    input  line_data_t             tl_d_data_i
);

    // call/return between the request fsm and the uncached master
    logic               unc_call;
    logic               unc_wreq;    // 1 = put, 0 = get
    logic [PADDR_W-1:0] unc_addr;
    tl_size_t           unc_size;
    line_strb_t         unc_mask;
    line_data_t         unc_wdata;
    logic               unc_done;    // single-cycle return pulse
    line_data_t         unc_rdata;

    cpu_req_ctrl crq_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .req_valid_i          (req_valid_i),
        .req_uncached_load_i  (req_uncached_load_i),
        .req_uncached_store_i (req_uncached_store_i),
        .req_size_i           (req_size_i),
        .req_paddr_i          (req_paddr_i),
        .req_wdata_i          (req_wdata_i),
        .wb_req_i             (wb_req_i),
        .wb_way_i             (wb_way_i),
        .wb_addr_i            (wb_addr_i),
        .wb_wstrb_i           (wb_wstrb_i),
        .wb_wdata_i           (wb_wdata_i),
        .unc_done_i           (unc_done),
        .unc_rdata_i          (unc_rdata),
        .resp_ready_o         (resp_ready_o),
        .resp_rdata_o         (resp_rdata_o),
        .unc_call_o           (unc_call),
        .unc_wreq_o           (unc_wreq),
        .unc_addr_o           (unc_addr),
        .unc_size_o           (unc_size),
        .unc_mask_o           (unc_mask),
        .unc_wdata_o          (unc_wdata),
        .m_way_o              (m_way_o),
        .m_addr_o             (m_addr_o),
        .m_wstrb_o            (m_wstrb_o),
        .m_wdata_o            (m_wdata_o)
    );

    uncached_tl_master unc_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .unc_call_i     (unc_call),
        .unc_wreq_i     (unc_wreq),
        .unc_addr_i     (unc_addr),
        .unc_size_i     (unc_size),
        .unc_mask_i     (unc_mask),
        .unc_wdata_i    (unc_wdata),
        .unc_done_o     (unc_done),
        .unc_rdata_o    (unc_rdata),
        .tl_a_valid_o   (tl_a_valid_o),
        .tl_a_ready_i   (tl_a_ready_i),
        .tl_a_opcode_o  (tl_a_opcode_o),
        .tl_a_size_o    (tl_a_size_o),
        .tl_a_address_o (tl_a_address_o),
        .tl_a_mask_o    (tl_a_mask_o),
        .tl_a_data_o    (tl_a_data_o),
        .tl_d_valid_i   (tl_d_valid_i),
        .tl_d_ready_o   (tl_d_ready_o),
        .tl_d_opcode_i  (tl_d_opcode_i),
        .tl_d_data_i    (tl_d_data_i)
    );

endmodule

/* verilog/wired_tl_pkg.sv */
// all widths follow the 128-bit tilelink line and only the uncached access opcodes are encoded
package wired_tl_pkg;

    // bus and line geometry
    localparam int unsigned PADDR_W     = 32;
    localparam int unsigned WORD_W      = 32;
    localparam int unsigned LINE_W      = 128;
    localparam int unsigned LINE_WORDS  = LINE_W / WORD_W;  // 4
    localparam int unsigned LINE_BYTES  = LINE_W / 8;       // a mask width, 16
    localparam int unsigned SRAM_ADDR_W = 12;               // byte address inside one way
    localparam int unsigned WAY_W       = 2;

    // cpu size codes, log2 of the byte count
    localparam logic [1:0] SZ_BYTE  = 2'd0;
    localparam logic [1:0] SZ_HALF  = 2'd1;
    localparam logic [1:0] SZ_WORD  = 2'd2;
    localparam logic [1:0] SZ_DWORD = 2'd3;

    // tilelink log2 size field
    typedef logic [3:0] tl_size_t;

    // channel a opcodes used by the uncached path
    typedef enum logic [2:0] {
        A_PUT_FULL_DATA = 3'd0,
        A_GET           = 3'd4
    } tl_a_op_e;

    // channel d opcodes answering them
    typedef enum logic [2:0] {
        D_ACCESS_ACK      = 3'd0,
        D_ACCESS_ACK_DATA = 3'd1
    } tl_d_op_e;

    // byte strobe of a single cpu word
    typedef logic [WORD_W/8-1:0] word_strb_t;

    // strobes of a whole line, one nibble per word
    typedef logic [LINE_WORDS-1:0][LINE_BYTES/LINE_WORDS-1:0] line_strb_t;

    // line payload, word 0 in the low bits
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_data_t;

endpackage

/* wired_tl_adapter.f */
verilog/wired_tl_pkg.sv
verilog/cpu_req_ctrl.sv
verilog/uncached_tl_master.sv
verilog/wired_tl_adapter.sv
verification/wired_tl_adapter_asserts.sv
verification/wired_tl_adapter_tb.sv
